//--- tb.f
+incdir+source
source/bird_game_pkg.sv
source/frame_random.sv
source/bird_logic.sv
source/dropping_logic.sv
source/object_render.sv
source/bird_game_top.sv
verification/bird_game_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= tb.f
TB_TOP    ?= bird_game_tb
RTL_TOP   ?= bird_game_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "no result in log"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/bird_game_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "bird_game_consts.svh"

module bird_game_tb;

	localparam int total_frames = 1000; // all tests together with slack

	logic clk = 1'b0;
	logic resetN;
	logic start_of_frame;
	bird_game_pkg::bird_ctrl_t ctrl;
	logic [10:0] pixel_x;
	logic [10:0] pixel_y;
	bird_game_pkg::obj_pos_t bird_pos;
	bird_game_pkg::obj_pos_t dropping_pos;
	bird_game_pkg::bird_status_t status;
	logic dropping_active, draw_bird, draw_dropping, draw_red;

	int seed = 32'h86ed_fa4d;
	int errors = 0;
	int tests = 0;
	int spawns = 0;   // droppings seen
	int bird_hits = 0; // pixels drawn on the bird
	// reference model
	logic sof_d, m_tick, m_tick_d, m_active, e_bird, e_drop, e_red;
	int m_life, m_red, m_since, m_need, m_dx, m_dy, m_prev_x, m_speed;

	bird_game_top bird_game_top_i (.*);

	always #2 clk = ~clk; // 4 ns period

	function automatic bit in_box(int p, int q, int ox, int oy, int w, int h);
		return (p >= ox) && (p < ox + w) && (q >= oy) && (q < oy + h);
	endfunction

	function automatic bit move_ok(int now, int prev, int spd);
		int d;
		int step;
		d = (now > prev) ? now - prev : prev - now;
		step = `FIXED_POINT_MULT + 32 * spd;
		return (d == 0) || (now == 0) || (now == `SCREEN_WIDTH - `BIRD_WIDTH) ||
			((d * 64 >= step - 64) && (d * 64 <= step + 64)); // within one pixel
	endfunction

	task automatic report_fail(string name, int expected, int actual);
		errors++;
		$display("Fail t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
	endtask

	always @(posedge clk or negedge resetN) begin : model
		int nl;
		bit hit;
		if (!resetN) begin
			{sof_d, m_tick, m_tick_d, m_active, e_bird, e_drop, e_red} <= '0;
			m_life   <= 0;
			m_red    <= 0;
			m_since  <= 0;
			m_need   <= `FIRST_COOLDOWN;
			m_dx     <= 0;
			m_dy     <= 0;
			m_prev_x <= `BIRD_INIT_X;
			m_speed  <= 0;
		end else begin
			sof_d    <= start_of_frame;
			m_tick   <= start_of_frame && !sof_d; // same edge rule as the dut
			m_tick_d <= m_tick;
			if (m_tick_d)
				m_prev_x <= bird_pos.x;
			if (m_tick) begin
				hit = ctrl.collision && (m_red == 0);
				nl  = ctrl.deploy ? ctrl.starting_life : m_life;
				if (hit)
					nl = (nl > ctrl.damage) ? nl - ctrl.damage : 0;
				m_life  <= nl;
				m_red   <= hit ? `RED_FRAMES : ((m_red > 0) ? m_red - 1 : 0);
				m_speed <= ctrl.speed;
				m_since <= (ctrl.deploy && m_life == 0) ? 0 : m_since + 1;
				if (ctrl.deploy && m_life == 0)
					m_need <= `FIRST_COOLDOWN;
				if (m_active) begin
					m_dy     <= m_dy + `DROP_FALL_STEP;
					m_active <= (m_dy + `DROP_FALL_STEP) < `SCREEN_HEIGHT;
				end
			end
			if (status.drop_release) begin
				m_since <= 0;
				m_need  <= `RELEASE_COOLDOWN;
				if (!m_active) begin // ignored while one is falling
					m_active <= 1'b1;
					m_dx     <= bird_pos.x + 8;
					m_dy     <= bird_pos.y + `BIRD_HEIGHT;
					spawns++;
				end
			end
			e_bird <= status.alive && in_box(pixel_x, pixel_y, bird_pos.x, bird_pos.y, 32, 32);
			e_red  <= status.red && status.alive &&
				in_box(pixel_x, pixel_y, bird_pos.x, bird_pos.y, 32, 32);
			e_drop <= dropping_active &&
				in_box(pixel_x, pixel_y, dropping_pos.x, dropping_pos.y, 16, 16);
			if (draw_bird)
				bird_hits++;
		end
	end

	a_red: assert property (@(posedge clk) disable iff (!resetN) status.red == (m_red != 0))
		else report_fail("status.red", $sampled(m_red != 0), $sampled(status.red));
	a_alive: assert property (@(posedge clk) disable iff (!resetN)
		status.alive == (m_life != 0 || m_red != 0))
		else report_fail("status.alive", $sampled(m_life != 0 || m_red != 0),
			$sampled(status.alive));
	a_release_gap: assert property (@(posedge clk) disable iff (!resetN)
		status.drop_release |-> (status.alive && m_since >= m_need))
		else report_fail("drop_release ticks since last", $sampled(m_need), $sampled(m_since));
	a_drop_active: assert property (@(posedge clk) disable iff (!resetN)
		dropping_active == m_active)
		else report_fail("dropping_active", $sampled(m_active), $sampled(dropping_active));
	a_drop_x: assert property (@(posedge clk) disable iff (!resetN)
		m_active |-> dropping_pos.x == m_dx)
		else report_fail("dropping_pos.x", $sampled(m_dx), $sampled(dropping_pos.x));
	a_drop_y: assert property (@(posedge clk) disable iff (!resetN)
		m_active |-> dropping_pos.y == m_dy)
		else report_fail("dropping_pos.y", $sampled(m_dy), $sampled(dropping_pos.y));
	a_move: assert property (@(posedge clk) disable iff (!resetN)
		m_tick_d |-> move_ok(bird_pos.x, m_prev_x, m_speed))
		else report_fail("bird_pos.x step", $sampled(m_prev_x), $sampled(bird_pos.x));
	a_x_range: assert property (@(posedge clk) disable iff (!resetN)
		bird_pos.x >= 0 && bird_pos.x <= `SCREEN_WIDTH - `BIRD_WIDTH)
		else report_fail("bird_pos.x range", 0, $sampled(bird_pos.x));
	a_y_fixed: assert property (@(posedge clk) disable iff (!resetN)
		bird_pos.y == `BIRD_INIT_Y)
		else report_fail("bird_pos.y", `BIRD_INIT_Y, $sampled(bird_pos.y));
	a_draw_bird: assert property (@(posedge clk) disable iff (!resetN) draw_bird == e_bird)
		else report_fail("draw_bird", $sampled(e_bird), $sampled(draw_bird));
	a_draw_drop: assert property (@(posedge clk) disable iff (!resetN)
		draw_dropping == e_drop)
		else report_fail("draw_dropping", $sampled(e_drop), $sampled(draw_dropping));
	a_draw_red: assert property (@(posedge clk) disable iff (!resetN) draw_red == e_red)
		else report_fail("draw_red", $sampled(e_red), $sampled(draw_red));

	// random pixels with about half aimed near an object
	always @(posedge clk) begin : pixels
		int r;
		r = $random(seed);
		if (r[0]) begin
			pixel_x <= 11'(bird_pos.x + (r[8:3] - 16));
			pixel_y <= 11'(r[1] ? bird_pos.y + (r[14:9] - 16) : dropping_pos.y + r[14:10]);
		end else begin
			pixel_x <= 11'((r >>> 4) & 11'h1ff);
			pixel_y <= 11'((r >>> 16) & 11'h1ff);
		end
	end

	task automatic run_frames(int n);
		repeat (n) begin
			@(posedge clk) start_of_frame <= 1'b1;
			@(posedge clk);
			@(posedge clk) start_of_frame <= 1'b0;
			repeat (13) @(posedge clk);
		end
	endtask

	task automatic set_ctrl(bit dep, bit col, int life, int spd, int dmg);
		@(posedge clk);
		ctrl <= '{deploy: dep, collision: col, starting_life: 4'(life),
			speed: 2'(spd), damage: 2'(dmg)};
	endtask

	task automatic end_test(string name);
		tests++;
		$display("test %s finished, errors so far %0d", name, errors);
	endtask

	initial begin
		resetN = 1'b0;
		start_of_frame = 1'b0;
		ctrl = '0;
		pixel_x = '0;
		pixel_y = '0;
		repeat (8) @(posedge clk);
		assert (status == '0 && !dropping_active && !draw_bird && !draw_dropping && !draw_red &&
				bird_pos.x == `BIRD_INIT_X && bird_pos.y == `BIRD_INIT_Y)
			else report_fail("reset outputs", 0, 1);
		@(posedge clk) resetN <= 1'b1;
		end_test("reset");
		set_ctrl(1, 0, 5, 1, 2);
		run_frames(1);
		set_ctrl(0, 0, 5, 1, 2);
		run_frames(3);
		set_ctrl(0, 1, 5, 1, 3); // later hits in this stretch land during red
		run_frames(3);
		set_ctrl(0, 0, 5, 1, 3);
		run_frames(34);
		set_ctrl(0, 1, 5, 1, 3); // damage above the life left saturates at zero
		run_frames(1);
		set_ctrl(0, 0, 5, 1, 3);
		run_frames(36);
		if (status.alive)
			report_fail("status.alive after death", 0, 1);
		end_test("life");
		set_ctrl(1, 0, 9, 3, 1);
		run_frames(1);
		set_ctrl(0, 0, 9, 3, 1);
		run_frames(80);
		end_test("motion");
		set_ctrl(0, 0, 9, 2, 1);
		run_frames(700);
		if (spawns < 2) begin
			errors++;
			$display("dropping test saw only %0d spawns, expected two or more", spawns);
		end
		end_test("dropping");
		run_frames(20);
		if (bird_hits == 0) begin
			errors++;
			$display("renderer never drew the bird");
		end
		end_test("render");
		$display("tests run %0d, checks failed %0d", tests, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin : watchdog
		#(total_frames * 16 * 4 + 2000);
		$display("timeout, the tests did not finish in time");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/bird_game_top.sv
`timescale 1ns/100ps
`default_nettype none

module bird_game_top (
	input  logic                        clk,
	input  logic                        resetN,
	input  logic                        start_of_frame,
	input  bird_game_pkg::bird_ctrl_t   ctrl,
	input  logic [10:0]                 pixel_x,
	input  logic [10:0]                 pixel_y,
	output bird_game_pkg::obj_pos_t     bird_pos,
	output bird_game_pkg::obj_pos_t     dropping_pos,
	output bird_game_pkg::bird_status_t status,
	output logic                        dropping_active,
	output logic                        draw_bird,
	output logic                        draw_dropping,
	output logic                        draw_red
);

	logic       frame_tick; // one cycle per frame
	logic [7:0] rnd;

	frame_random frame_random_i (
		.clk(clk), .resetN(resetN), .start_of_frame(start_of_frame),
		.frame_tick(frame_tick), .rnd(rnd)
	);

	bird_logic #(.random_offset(0)) bird_logic_i (
		.clk(clk), .resetN(resetN), .frame_tick(frame_tick), .rnd(rnd),
		.ctrl(ctrl), .bird_pos(bird_pos), .status(status)
	);

	dropping_logic dropping_logic_i (
		.clk(clk), .resetN(resetN), .frame_tick(frame_tick),
		.drop_release(status.drop_release), .bird_pos(bird_pos),
		.dropping_pos(dropping_pos), .dropping_active(dropping_active)
	);

	object_render object_render_i (
		.clk(clk), .resetN(resetN), .pixel_x(pixel_x), .pixel_y(pixel_y),
		.bird_pos(bird_pos), .dropping_pos(dropping_pos),
		.alive(status.alive), .red(status.red), .dropping_active(dropping_active),
		.draw_bird(draw_bird), .draw_dropping(draw_dropping), .draw_red(draw_red)
	);

endmodule

`default_nettype wire

//--- source/object_render.sv
`timescale 1ns/100ps
`default_nettype none
`include "bird_game_consts.svh"

module object_render (
	input  logic                    clk,
	input  logic                    resetN,
	input  logic [10:0]             pixel_x,
	input  logic [10:0]             pixel_y,
	input  bird_game_pkg::obj_pos_t bird_pos,
	input  bird_game_pkg::obj_pos_t dropping_pos,
	input  logic                    alive,
	input  logic                    red,
	input  logic                    dropping_active,
	output logic                    draw_bird,
	output logic                    draw_dropping,
	output logic                    draw_red     // tint request for the bird
);

	logic signed [11:0] px;
	logic signed [11:0] py;
	logic signed [11:0] bx; // sign extended corners
	logic signed [11:0] by;
	logic signed [11:0] dx;
	logic signed [11:0] dy;
	logic               in_bird;
	logic               in_drop;

	assign px = $signed({1'b0, pixel_x}); // pixels are never negative
	assign py = $signed({1'b0, pixel_y});
	assign bx = bird_pos.x;
	assign by = bird_pos.y;
	assign dx = dropping_pos.x;
	assign dy = dropping_pos.y;

	assign in_bird = alive && (px >= bx) && (px < bx + `BIRD_WIDTH) &&
			(py >= by) && (py < by + `BIRD_HEIGHT);
	assign in_drop = dropping_active && (px >= dx) && (px < dx + `DROP_WIDTH) &&
			(py >= dy) && (py < dy + `DROP_HEIGHT);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			draw_bird     <= 1'b0;
			draw_dropping <= 1'b0;
			draw_red      <= 1'b0;
		end else begin
			draw_bird     <= in_bird;
			draw_dropping <= in_drop;
			draw_red      <= in_bird && red; // same pixel as draw_bird
		end
	end

endmodule

`default_nettype wire

//--- source/dropping_logic.sv
`timescale 1ns/100ps
`default_nettype none
`include "bird_game_consts.svh"

module dropping_logic (
	input  logic                    clk,
	input  logic                    resetN,
	input  logic                    frame_tick,
	input  logic                    drop_release, // strobe from the bird
	input  bird_game_pkg::obj_pos_t bird_pos,
	output bird_game_pkg::obj_pos_t dropping_pos,
	output logic                    dropping_active
);

	localparam logic signed [10:0] spawn_dx  = 11'((`BIRD_WIDTH - `DROP_WIDTH) / 2); // centred
	localparam logic signed [10:0] spawn_dy  = 11'(`BIRD_HEIGHT);                      // below bird
	localparam logic signed [10:0] fall_step = 11'(`DROP_FALL_STEP);
	localparam logic signed [10:0] bottom    = 11'(`SCREEN_HEIGHT);

	logic               spawn;
	logic signed [10:0] y_next;

	assign spawn  = drop_release && !dropping_active; // one dropping at a time
	assign y_next = dropping_pos.y + fall_step;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			dropping_active <= 1'b0;
		end else if (spawn) begin
			dropping_active <= 1'b1;
		end else if (frame_tick && dropping_active && (y_next >= bottom)) begin
			dropping_active <= 1'b0; // fell off the screen
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			dropping_pos <= '0;
		end else if (spawn) begin
			dropping_pos.x <= bird_pos.x + spawn_dx;
			dropping_pos.y <= bird_pos.y + spawn_dy;
		end else if (frame_tick && dropping_active) begin
			dropping_pos.y <= y_next;
		end
	end

endmodule

`default_nettype wire

//--- source/bird_logic.sv
`timescale 1ns/100ps
`default_nettype none
`include "bird_game_consts.svh"

module bird_logic #(
	parameter int random_offset = 0 // decorrelates several birds
) (
	input  logic                        clk,
	input  logic                        resetN,
	input  logic                        frame_tick,
	input  logic [7:0]                  rnd,
	input  bird_game_pkg::bird_ctrl_t   ctrl,
	output bird_game_pkg::obj_pos_t     bird_pos,
	output bird_game_pkg::bird_status_t status
);

	localparam logic [15:0] max_x_fp = 16'((`SCREEN_WIDTH - `BIRD_WIDTH) * `FIXED_POINT_MULT);
	localparam logic [15:0] edge_fp  = 16'(2 * `BIRD_WIDTH * `FIXED_POINT_MULT); // turn-back zone
	localparam logic [8:0]  offset_mod = 9'(random_offset % 255);

	bird_game_pkg::motion_t state;
	bird_game_pkg::motion_t next_state;
	logic [8:0]  rnd_sum;
	logic [7:0]  rnd_off;   // offset random byte
	logic [7:0]  step;      // fixed-point move per frame
	logic [15:0] x_fp;      // x in 1/64 pixel
	logic [15:0] x_next;
	logic [3:0]  life;
	logic [3:0]  life_next;
	logic [5:0]  red_cnt;   // frames of flash left
	logic [9:0]  cooldown;  // frames until next dropping allowed
	logic        release_q;
	logic        red;
	logic        hit;       // collision that counts

	always_comb begin
		rnd_sum = {1'b0, rnd} + offset_mod;
		rnd_off = (rnd_sum >= 9'd255) ? 8'(rnd_sum - 9'd255) : rnd_sum[7:0]; // wrap
	end

	assign step = 8'(`FIXED_POINT_MULT + 32 * ctrl.speed);
	assign red  = red_cnt != 6'd0;
	assign hit  = ctrl.collision && !red; // no damage while flashing

	always_comb begin
		next_state = state;
		if (frame_tick && (rnd_off < 8'(`TURN_THRESHOLD))) begin
			if (state == bird_game_pkg::idle) begin
				if (x_fp < edge_fp)
					next_state = bird_game_pkg::right; // too close to left border
				else if (x_fp > max_x_fp - edge_fp)
					next_state = bird_game_pkg::left;
				else if (rnd_off < 8'(`TURN_THRESHOLD / 2))
					next_state = bird_game_pkg::right;
				else
					next_state = bird_game_pkg::left;
			end else begin
				next_state = bird_game_pkg::idle; // every move ends in a pause
			end
		end
	end

	// clamped x step
	always_comb begin
		case (state)
			bird_game_pkg::right:
				x_next = (x_fp > max_x_fp - 16'(step)) ? max_x_fp : x_fp + 16'(step);
			bird_game_pkg::left:
				x_next = (x_fp < 16'(step)) ? 16'd0 : x_fp - 16'(step);
			default:
				x_next = x_fp;
		endcase
	end

	always_comb begin
		life_next = ctrl.deploy ? ctrl.starting_life : life;
		if (hit)
			life_next = (life_next > 4'(ctrl.damage)) ? life_next - 4'(ctrl.damage) : 4'd0;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state     <= bird_game_pkg::idle;
			x_fp      <= 16'(`BIRD_INIT_X * `FIXED_POINT_MULT);
			life      <= 4'd0;
			red_cnt   <= 6'd0;
			cooldown  <= 10'(`FIRST_COOLDOWN);
			release_q <= 1'b0;
		end else begin
			state     <= next_state;
			release_q <= 1'b0; // strobe
			if (frame_tick) begin
				x_fp <= x_next;
				life <= life_next;
				if (hit)
					red_cnt <= 6'(`RED_FRAMES); // restart flash
				else if (red)
					red_cnt <= red_cnt - 6'd1;
				if (ctrl.deploy && (life == 4'd0))
					cooldown <= 10'(`FIRST_COOLDOWN); // fresh bird waits again
				else if ((life != 4'd0) && (cooldown != 10'd0))
					cooldown <= cooldown - 10'd1;
				if ((life != 4'd0) && (cooldown == 10'd0) &&
						(rnd_off > 8'(`RELEASE_THRESHOLD))) begin
					release_q <= 1'b1;
					cooldown  <= 10'(`RELEASE_COOLDOWN);
				end
			end
		end
	end

	assign bird_pos = '{x: 11'(x_fp / `FIXED_POINT_MULT), y: 11'(`BIRD_INIT_Y)};
	assign status   = '{alive: (life != 4'd0) || red, red: red, drop_release: release_q};

	a_release_single: assert property (@(posedge clk) disable iff (!resetN)
		release_q |=> !release_q);

endmodule

`default_nettype wire

//--- source/frame_random.sv
`timescale 1ns/100ps
`default_nettype none

module frame_random (
	input  logic       clk,
	input  logic       resetN,
	input  logic       start_of_frame, // may stay high for several cycles
	output logic       frame_tick,     // single cycle per frame
	output logic [7:0] rnd
);

	logic sof_d; // start_of_frame one cycle late

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			sof_d      <= 1'b0;
			frame_tick <= 1'b0;
			rnd        <= 8'hA5; // any non-zero seed
		end else begin
			sof_d      <= start_of_frame;
			frame_tick <= start_of_frame && !sof_d; // rising edge only
			if (frame_tick)
				rnd <= {rnd[6:0], rnd[7] ^ rnd[5] ^ rnd[4] ^ rnd[3]}; // x^8+x^6+x^5+x^4+1
		end
	end

	// the lfsr locks up for good if it ever hits zero
	a_rnd_nonzero: assert property (@(posedge clk) disable iff (!resetN)
		rnd != 8'h00);

endmodule

`default_nettype wire

//--- source/bird_game_pkg.sv
`default_nettype none

package bird_game_pkg;

	// top-left corner of a sprite in screen pixels
	typedef struct packed {
		logic signed [10:0] x; // may go negative near the left border
		logic signed [10:0] y;
	} obj_pos_t;

	typedef struct packed {
		logic alive;        // life left, or still flashing red
		logic red;          // hit flash running
		logic drop_release; // one-cycle strobe to the dropping block
	} bird_status_t;

	typedef struct packed {
		logic       deploy;        // level that loads starting_life on a tick
		logic       collision;     // level sampled on a tick
		logic [3:0] starting_life;
		logic [1:0] speed;         // adds 32/64 pixel per step
		logic [1:0] damage;        // life lost per hit
	} bird_ctrl_t;

	typedef enum logic [1:0] {
		idle,
		right,
		left
	} motion_t;

endpackage

`default_nettype wire

//--- source/bird_game_consts.svh
`ifndef BIRD_GAME_CONSTS_SVH
`define BIRD_GAME_CONSTS_SVH

`define SCREEN_WIDTH 640
`define SCREEN_HEIGHT 480

`define BIRD_WIDTH 32
`define BIRD_HEIGHT 32
`define DROP_WIDTH 16
`define DROP_HEIGHT 16

`define FIXED_POINT_MULT 64 // 1/64 pixel resolution as a power of two

`define BIRD_INIT_X 280
`define BIRD_INIT_Y 185

`define RED_FRAMES 32        // length of the hit flash
`define FIRST_COOLDOWN 100   // frames before the first dropping
`define RELEASE_COOLDOWN 500 // frames between droppings

`define TURN_THRESHOLD 8     // random below this turns the bird
`define RELEASE_THRESHOLD 240
`define DROP_FALL_STEP 4     // pixels per frame

`endif
